/* logic/devil_pkg.sv */
`default_nettype none

package devil_pkg;

    // ----------------------------------------------------------------------
    // ACE line format
    // ----------------------------------------------------------------------
    localparam int WORD_W     = 32;
    localparam int CL_WORDS   = 16;          // 64-byte line
    localparam int ACE_ADDR_W = 44;

    localparam logic [1:0] DOMAIN_OUTER = 2'b10;   // Outer shareable

    typedef logic [CL_WORDS*WORD_W-1:0] cache_line_t;  // Word 0 in bits 31:0
    typedef logic [4:0]                 pattern_len_t; // 1 to 16 words

    // ----------------------------------------------------------------------
    // Commands, snoop functions and controller states
    // ----------------------------------------------------------------------
    // Anything other than leak or poison means no action
    typedef enum logic [3:0] {
        CMD_LEAK   = 4'd0,
        CMD_POISON = 4'd1
    } devil_cmd_e;

    typedef enum logic [3:0] {
        FUNC_NONE = 4'd0,
        FUNC_ADL  = 4'd1,    // Read snoop
        FUNC_ADT  = 4'd2     // Write snoop
    } active_func_e;

    typedef enum logic [3:0] {
        ST_IDLE       = 4'd0,
        ST_SEARCH     = 4'd1,
        ST_MATCH_WAIT = 4'd2,
        ST_CHOOSE_CMD = 4'd3,
        ST_LEAK       = 4'd4,
        ST_POISON     = 4'd5,
        ST_REPLY      = 4'd6,
        ST_END_OP     = 4'd7
    } ctrl_state_e;

    // ----------------------------------------------------------------------
    // Request to the snoopers and register-file configuration
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [ACE_ADDR_W-1:0] araddr;
        logic [3:0]            arsnoop;
        logic [ACE_ADDR_W-1:0] awaddr;
        logic [2:0]            awsnoop;
        logic [1:0]            ardomain;
        active_func_e          active_func;
        logic                  reply;        // Line ready for the passive side
    } snoop_req_t;

    typedef struct packed {
        cache_line_t  poison_line;   // Data for the write snoop
        cache_line_t  pattern;       // Pattern word 0 matches first
        pattern_len_t pattern_len;
        logic [3:0]   arsnoop;
        logic [2:0]   awsnoop;
        logic [31:0]  l_araddr;      // Zero-extended into the request
        logic [31:0]  l_awaddr;
    } attack_cfg_t;

endpackage

`default_nettype wire

/* logic/devil_pattern_matcher.sv */
`timescale 1ns/1ps
`default_nettype none

module devil_pattern_matcher
(
    input  wire                           ace_aclk,
    input  wire                           ace_aresetn,
    input  wire logic                     i_start,
    input  wire devil_pkg::cache_line_t   i_line,
    input  wire devil_pkg::cache_line_t   i_pattern,
    input  wire devil_pkg::pattern_len_t  i_pattern_len,
    output logic                          o_done,
    output logic                          o_match
);

    import devil_pkg::*;

    logic        busy;
    logic [3:0]  offset;         // Word offset under test
    logic [4:0]  last_offset;    // Last offset where the pattern still fits
    logic        len_ok;
    logic        at_last;
    logic        hit;
    cache_line_t line_win;
    cache_line_t len_mask;

    // ----------------------------------------------------------------------
    // Compare one window per cycle
    // ----------------------------------------------------------------------
    // Slide the line down so the word at offset lands on pattern word 0
    assign line_win = i_line >> (WORD_W * offset);

    // Ones over the low len words; len 16 wraps to all ones
    assign len_mask = (cache_line_t'(1) << (WORD_W * i_pattern_len)) - cache_line_t'(1);

    assign hit = ((line_win ^ i_pattern) & len_mask) == '0;

    assign last_offset = 5'(CL_WORDS) - i_pattern_len;
    assign at_last     = ({1'b0, offset} == last_offset);

    // Zero or over-long patterns end at once with no match
    assign len_ok = (i_pattern_len != '0) && (i_pattern_len <= 5'(CL_WORDS));

    assign o_done  = busy && (!len_ok || hit || at_last);
    assign o_match = busy && len_ok && hit;  // Valid with o_done

    // ----------------------------------------------------------------------
    // Offset counter
    // ----------------------------------------------------------------------
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            busy   <= 1'b0;
            offset <= '0;
        end
        else if (!busy)
        begin
            if (i_start)
            begin
                busy   <= 1'b1;
                offset <= '0;             // First window at word 0
            end
        end
        else if (o_done)
        begin
            busy <= 1'b0;                 // Start while busy is dropped
        end
        else
        begin
            offset <= offset + 4'd1;
        end
    end

endmodule

`default_nettype wire

/* logic/devil_controller_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module devil_controller_fsm
(
    input  wire                           ace_aclk,
    input  wire                           ace_aresetn,
    input  wire logic                     i_trigger,
    input  wire devil_pkg::devil_cmd_e    i_cmd,
    input  wire devil_pkg::attack_cfg_t   i_cfg,
    input  wire logic                     i_end_active,
    input  wire devil_pkg::cache_line_t   i_cache_line_active,
    input  wire logic                     i_end_reply,
    input  wire logic                     i_match_done,
    input  wire logic                     i_match,
    output logic                          o_match_start,
    output devil_pkg::cache_line_t        o_match_line,
    output devil_pkg::ctrl_state_e        o_state,
    output devil_pkg::snoop_req_t         o_snoop_req,
    output logic                          o_adl_en,
    output logic                          o_adt_en,
    output logic                          o_trigger_active,
    output devil_pkg::cache_line_t        o_cache_line_active,
    output devil_pkg::cache_line_t        o_cache_line_passive
);

    import devil_pkg::*;

    // ----------------------------------------------------------------------
    // Snooped line store
    // ----------------------------------------------------------------------
    // Held from the search until the next one, feeds matcher and reply
    always_ff @(posedge ace_aclk)
    begin
        if (o_state == ST_SEARCH && i_end_active)
        begin
            o_match_line <= i_cache_line_active;
        end
    end

    // ----------------------------------------------------------------------
    // Attack sequence
    // ----------------------------------------------------------------------
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            o_state              <= ST_IDLE;
            o_match_start        <= 1'b0;
            o_snoop_req          <= '0;
            o_adl_en             <= 1'b0;
            o_adt_en             <= 1'b0;
            o_trigger_active     <= 1'b0;
            o_cache_line_active  <= '0;
            o_cache_line_passive <= '0;
        end
        else
        begin
            o_match_start <= 1'b0;   // Single-cycle pulse

            case (o_state)
                ST_IDLE:
                begin
                    if (i_trigger)
                    begin
                        o_state <= ST_SEARCH;
                    end
                end

                ST_SEARCH:
                begin
                    // Active snooper hands over the line
                    if (i_end_active)
                    begin
                        o_match_start <= 1'b1;
                        o_state       <= ST_MATCH_WAIT;
                    end
                end

                ST_MATCH_WAIT:
                begin
                    if (i_match_done)
                    begin
                        o_state <= i_match ? ST_CHOOSE_CMD : ST_REPLY;
                    end
                end

                ST_CHOOSE_CMD:
                begin
                    case (i_cmd)
                        CMD_LEAK:   o_state <= ST_LEAK;
                        CMD_POISON: o_state <= ST_POISON;
                        default:    o_state <= ST_END_OP;   // No action, no reply
                    endcase
                end

                ST_LEAK:
                begin
                    o_snoop_req.araddr      <= ACE_ADDR_W'(i_cfg.l_araddr);
                    o_snoop_req.arsnoop     <= i_cfg.arsnoop;
                    o_snoop_req.ardomain    <= DOMAIN_OUTER;
                    o_snoop_req.active_func <= FUNC_ADL;
                    o_adl_en                <= 1'b1;
                    o_trigger_active        <= 1'b1;

                    // End pulse only counts once the read snoop is launched
                    if (i_end_active && o_trigger_active)
                    begin
                        o_state <= ST_REPLY;
                    end
                end

                ST_POISON:
                begin
                    o_snoop_req.awaddr      <= ACE_ADDR_W'(i_cfg.l_awaddr);
                    o_snoop_req.awsnoop     <= i_cfg.awsnoop;
                    o_snoop_req.ardomain    <= DOMAIN_OUTER;
                    o_snoop_req.active_func <= FUNC_ADT;
                    o_cache_line_active     <= i_cfg.poison_line;  // Write snoop data
                    o_adt_en                <= 1'b1;
                    o_trigger_active        <= 1'b1;

                    if (i_end_active && o_trigger_active)
                    begin
                        o_state <= ST_REPLY;
                    end
                end

                ST_REPLY:
                begin
                    o_trigger_active     <= 1'b0;
                    o_adl_en             <= 1'b0;
                    o_adt_en             <= 1'b0;
                    o_snoop_req.reply    <= 1'b1;
                    o_cache_line_passive <= o_match_line;  // Saved line back out

                    // Passive side done with the reply
                    if (i_end_reply && o_snoop_req.reply)
                    begin
                        o_state <= ST_END_OP;
                    end
                end

                ST_END_OP:
                begin
                    o_snoop_req.reply <= 1'b0;
                    o_state           <= ST_IDLE;
                end

                default:
                begin
                    o_state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/devil_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module devil_controller
(
    input  wire                           ace_aclk,
    input  wire                           ace_aresetn,
    input  wire logic                     i_trigger,
    input  wire devil_pkg::devil_cmd_e    i_cmd,
    input  wire devil_pkg::attack_cfg_t   i_cfg,
    input  wire logic                     i_end_active,
    input  wire devil_pkg::cache_line_t   i_cache_line_active,
    input  wire logic                     i_end_reply,
    output devil_pkg::ctrl_state_e        o_state,
    output devil_pkg::snoop_req_t         o_snoop_req,
    output logic                          o_adl_en,
    output logic                          o_adt_en,
    output logic                          o_trigger_active,
    output devil_pkg::cache_line_t        o_cache_line_active,
    output devil_pkg::cache_line_t        o_cache_line_passive
);

    import devil_pkg::*;

    // Controller to matcher
    logic        match_start;
    cache_line_t match_line;
    logic        match_done;
    logic        match_hit;

    devil_controller_fsm u_fsm
    (
        .ace_aclk             (ace_aclk),
        .ace_aresetn          (ace_aresetn),
        .i_trigger            (i_trigger),
        .i_cmd                (i_cmd),
        .i_cfg                (i_cfg),
        .i_end_active         (i_end_active),
        .i_cache_line_active  (i_cache_line_active),
        .i_end_reply          (i_end_reply),
        .i_match_done         (match_done),
        .i_match              (match_hit),
        .o_match_start        (match_start),
        .o_match_line         (match_line),
        .o_state              (o_state),
        .o_snoop_req          (o_snoop_req),
        .o_adl_en             (o_adl_en),
        .o_adt_en             (o_adt_en),
        .o_trigger_active     (o_trigger_active),
        .o_cache_line_active  (o_cache_line_active),
        .o_cache_line_passive (o_cache_line_passive)
    );

    // Pattern fields come straight from the register file
    devil_pattern_matcher u_matcher
    (
        .ace_aclk      (ace_aclk),
        .ace_aresetn   (ace_aresetn),
        .i_start       (match_start),
        .i_line        (match_line),
        .i_pattern     (i_cfg.pattern),
        .i_pattern_len (i_cfg.pattern_len),
        .o_done        (match_done),
        .o_match       (match_hit)
    );

endmodule

`default_nettype wire

/* testbench/devil_controller_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module devil_controller_assert
(
    input wire                          ace_aclk,
    input wire                          ace_aresetn,
    input wire devil_pkg::ctrl_state_e  i_state,
    input wire devil_pkg::snoop_req_t   i_snoop_req,
    input wire logic                    i_adl_en,
    input wire logic                    i_adt_en,
    input wire logic                    i_trigger_active
);

    import devil_pkg::*;

    // Only one snoop kind in flight
    one_enable: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        !(i_adl_en && i_adt_en))
        else $error("read and write snoop enables high together");

    enable_needs_trigger: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        (i_adl_en || i_adt_en) |-> i_trigger_active)
        else $error("snoop enable high without trigger_active");

    no_reply_in_idle: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        (i_state == ST_IDLE) |-> !i_snoop_req.reply)   // Reply cleared before idle
        else $error("reply field high in idle");

endmodule

bind devil_controller devil_controller_assert u_assert
(
    .ace_aclk         (ace_aclk),
    .ace_aresetn      (ace_aresetn),
    .i_state          (o_state),
    .i_snoop_req      (o_snoop_req),
    .i_adl_en         (o_adl_en),
    .i_adt_en         (o_adt_en),
    .i_trigger_active (o_trigger_active)
);

`default_nettype wire

/* testbench/tb_devil_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_devil_controller;

    import devil_pkg::*;

    typedef logic [511:0] wide_t;

    // One row of the case file
    typedef struct packed {
        logic [3:0]  cmd;
        logic [4:0]  pat_len;
        logic [31:0] line_seed;
        logic [4:0]  pat_off;
        logic [31:0] pat_xor;
        logic [31:0] poison_seed;
        logic [3:0]  arsnoop;
        logic [2:0]  awsnoop;
        logic [31:0] araddr;
        logic [31:0] awaddr;
        logic        match;
    } case_t;

    logic         ace_aclk;
    logic         ace_aresetn;
    logic         i_trigger;
    devil_cmd_e   i_cmd;
    attack_cfg_t  i_cfg;
    logic         i_end_active;
    cache_line_t  i_cache_line_active;
    logic         i_end_reply;
    ctrl_state_e  o_state;
    snoop_req_t   o_snoop_req;
    logic         o_adl_en;
    logic         o_adt_en;
    logic         o_trigger_active;
    cache_line_t  o_cache_line_active;
    cache_line_t  o_cache_line_passive;

    case_t cases[$];
    int    n_cases   = 0;
    int    err_count = 0;

    devil_controller dut0
    (
        .ace_aclk             (ace_aclk),
        .ace_aresetn          (ace_aresetn),
        .i_trigger            (i_trigger),
        .i_cmd                (i_cmd),
        .i_cfg                (i_cfg),
        .i_end_active         (i_end_active),
        .i_cache_line_active  (i_cache_line_active),
        .i_end_reply          (i_end_reply),
        .o_state              (o_state),
        .o_snoop_req          (o_snoop_req),
        .o_adl_en             (o_adl_en),
        .o_adt_en             (o_adt_en),
        .o_trigger_active     (o_trigger_active),
        .o_cache_line_active  (o_cache_line_active),
        .o_cache_line_passive (o_cache_line_passive)
    );

    initial
    begin
        ace_aclk = 1'b0;
        forever
        begin
            #2 ace_aclk = ~ace_aclk;   // 4 ns period
        end
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    task automatic compare(input string what, input wide_t got, input wide_t exp);
        if (got !== exp)
        begin
            $display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
            err_count++;
        end
    endtask

    // Words first .. first+count-1 of an endless fill, packed from word 0 up
    function automatic cache_line_t fill_words(input logic [31:0] seed, input int first,
                                               input int count);
        cache_line_t res;
        res = '0;
        for (int i = 0; i < CL_WORDS; i++)
        begin
            if (i < count)
            begin
                res[i*WORD_W +: WORD_W] = seed + 32'(first + i) * 32'h1357_9bdf;
            end
        end
        return res;
    endfunction

    function automatic int pick_delay();
        return 1 + int'($urandom % 32'd6);   // 1 to 6 cycles
    endfunction

    task automatic load_cases();
        int          fd;
        int          n;
        string       s;
        byte         ch;
        logic [31:0] f [11];
        case_t       c;
        fd = $fopen("testbench/devil_cases.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the case file testbench/devil_cases.txt");
            return;
        end
        while ($fgets(s, fd) != 0)
        begin
            ch = (s.len() > 0) ? s.getc(0) : "#";
            if (ch != "#" && ch != "\n")
            begin
                n = $sscanf(s, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                            f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                if (n != 11)
                begin
                    $display("case file line has %0d fields instead of 11: %s", n, s);
                    err_count++;
                end
                else
                begin
                    c.cmd         = f[0][3:0];
                    c.pat_len     = f[1][4:0];
                    c.line_seed   = f[2];
                    c.pat_off     = f[3][4:0];
                    c.pat_xor     = f[4];
                    c.poison_seed = f[5];
                    c.arsnoop     = f[6][3:0];
                    c.awsnoop     = f[7][2:0];
                    c.araddr      = f[8];
                    c.awaddr      = f[9];
                    c.match       = f[10][0];
                    cases.push_back(c);
                end
            end
        end
        $fclose(fd);
        n_cases = cases.size();
    endtask

    task automatic run_case(input int idx);
        case_t       c;
        attack_cfg_t cfg;
        cache_line_t line;
        cache_line_t active_en;
        cache_line_t passive;
        snoop_req_t  req_en;
        logic        exp_leak;
        logic        exp_poison;
        logic        exp_reply;
        logic        saw_adl;
        logic        saw_adt;
        logic        saw_reply;
        logic        saw_choose;
        logic        saw_trig;
        logic        started;
        logic        finished;
        int          errs_before;
        c            = cases[idx];
        errs_before  = err_count;
        line         = fill_words(c.line_seed, 0, CL_WORDS);
        cfg.pattern  = fill_words(c.line_seed, int'(c.pat_off), int'(c.pat_len))
                       ^ cache_line_t'(c.pat_xor);
        cfg.poison_line = fill_words(c.poison_seed, 0, CL_WORDS);
        cfg.pattern_len = c.pat_len;
        cfg.arsnoop     = c.arsnoop;
        cfg.awsnoop     = c.awsnoop;
        cfg.l_araddr    = c.araddr;
        cfg.l_awaddr    = c.awaddr;
        exp_leak   = c.match && (c.cmd == 4'd0);
        exp_poison = c.match && (c.cmd == 4'd1);
        exp_reply  = !c.match || (c.cmd <= 4'd1);   // Unknown command skips the reply
        saw_adl    = 1'b0;
        saw_adt    = 1'b0;
        saw_reply  = 1'b0;
        saw_choose = 1'b0;
        saw_trig   = 1'b0;
        started    = 1'b0;
        finished   = 1'b0;
        req_en     = '0;
        active_en  = '0;
        passive    = '0;

        @(posedge ace_aclk);
        i_cmd               <= devil_cmd_e'(c.cmd);
        i_cfg               <= cfg;
        i_cache_line_active <= line;
        i_trigger           <= 1'b1;
        @(posedge ace_aclk);
        i_trigger <= 1'b0;

        // Follow the operation until the FSM is back in idle
        while (!finished)
        begin
            @(negedge ace_aclk);
            if (o_adl_en)
            begin
                saw_adl = 1'b1;
                req_en  = o_snoop_req;
            end
            if (o_adt_en)
            begin
                saw_adt   = 1'b1;
                req_en    = o_snoop_req;
                active_en = o_cache_line_active;
            end
            if (o_trigger_active)
                saw_trig = 1'b1;
            if (o_snoop_req.reply)
            begin
                saw_reply = 1'b1;
                passive   = o_cache_line_passive;
            end
            if (o_state == ST_CHOOSE_CMD)
                saw_choose = 1'b1;
            if (o_state != ST_IDLE)
                started = 1'b1;
            else if (started)
                finished = 1'b1;
        end

        compare("command stage reached", wide_t'(saw_choose), wide_t'(c.match));
        compare("adl_en seen", wide_t'(saw_adl), wide_t'(exp_leak));
        compare("adt_en seen", wide_t'(saw_adt), wide_t'(exp_poison));
        compare("trigger_active seen", wide_t'(saw_trig), wide_t'(exp_leak || exp_poison));
        compare("reply seen", wide_t'(saw_reply), wide_t'(exp_reply));
        if (exp_leak)
        begin
            compare("araddr", wide_t'(req_en.araddr), wide_t'(c.araddr));
            compare("arsnoop", wide_t'(req_en.arsnoop), wide_t'(c.arsnoop));
            compare("ardomain", wide_t'(req_en.ardomain), wide_t'(DOMAIN_OUTER));
            compare("leak func", wide_t'(req_en.active_func), wide_t'(FUNC_ADL));
        end
        if (exp_poison)
        begin
            compare("awaddr", wide_t'(req_en.awaddr), wide_t'(c.awaddr));
            compare("awsnoop", wide_t'(req_en.awsnoop), wide_t'(c.awsnoop));
            compare("ardomain", wide_t'(req_en.ardomain), wide_t'(DOMAIN_OUTER));
            compare("poison func", wide_t'(req_en.active_func), wide_t'(FUNC_ADT));
            compare("poison line", wide_t'(active_en), wide_t'(cfg.poison_line));
        end
        if (exp_reply)
            compare("reply line", wide_t'(passive), wide_t'(line));
        compare("reply after end", wide_t'(o_snoop_req.reply), wide_t'(1'b0));
        compare("trigger_active after end", wide_t'(o_trigger_active), wide_t'(1'b0));
        $display("test %0d cmd %0h match %0d: %s", idx + 1, c.cmd, c.match,
                 (err_count == errs_before) ? "ok" : "mismatch");
    endtask

    // ----------------------------------------------------------------------
    // Snooper model for the active and passive sides
    // ----------------------------------------------------------------------
    logic act_req;
    logic rep_req;
    logic act_served;
    logic rep_served;
    int   act_cnt;
    int   rep_cnt;

    assign act_req = (o_state == ST_SEARCH) || o_adl_en || o_adt_en;
    assign rep_req = o_snoop_req.reply;

    initial
    begin : snooper
        i_end_active <= 1'b0;
        i_end_reply  <= 1'b0;
        act_served = 1'b0;
        rep_served = 1'b0;
        act_cnt    = 0;
        rep_cnt    = 0;
        forever
        begin
            @(posedge ace_aclk);
            i_end_active <= 1'b0;
            i_end_reply  <= 1'b0;
            if (!ace_aresetn)
            begin
                act_served = 1'b0;
                rep_served = 1'b0;
                act_cnt    = 0;
                rep_cnt    = 0;
            end
            else
            begin
                // One end pulse per handover or snoop request
                if (act_cnt == 1)
                begin
                    i_end_active <= 1'b1;
                    act_cnt    = 0;
                    act_served = 1'b1;
                end
                else if (act_cnt > 1)
                    act_cnt = act_cnt - 1;
                else if (!act_req)
                    act_served = 1'b0;
                else if (!act_served)
                    act_cnt = pick_delay();

                if (rep_cnt == 1)
                begin
                    i_end_reply <= 1'b1;
                    rep_cnt    = 0;
                    rep_served = 1'b1;
                end
                else if (rep_cnt > 1)
                    rep_cnt = rep_cnt - 1;
                else if (!rep_req)
                    rep_served = 1'b0;
                else if (!rep_served)
                    rep_cnt = pick_delay();
            end
        end
    end

    initial
    begin : watchdog
        wait (n_cases > 0);
        repeat (n_cases * 200 + 8) @(posedge ace_aclk);
        $display("watchdog expired, the run did not finish in %0d cycles", n_cases * 200);
        $display("tests failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial
    begin : main
        int errs_before;
        ace_aresetn         <= 1'b0;
        i_trigger           <= 1'b0;
        i_cmd               <= CMD_LEAK;
        i_cfg               <= '0;
        i_cache_line_active <= '0;
        void'($urandom(32'hb250_4ef4));
        load_cases();
        if (n_cases == 0)
        begin
            $display("no test cases were loaded");
            err_count++;
        end
        repeat (8) @(posedge ace_aclk);
        ace_aresetn <= 1'b1;

        @(negedge ace_aclk);
        errs_before = err_count;
        compare("reset state", wide_t'(o_state), wide_t'(ST_IDLE));
        compare("reset adl_en", wide_t'(o_adl_en), wide_t'(1'b0));
        compare("reset adt_en", wide_t'(o_adt_en), wide_t'(1'b0));
        compare("reset trigger_active", wide_t'(o_trigger_active), wide_t'(1'b0));
        compare("reset request", wide_t'(o_snoop_req), wide_t'(0));
        compare("reset active line", wide_t'(o_cache_line_active), wide_t'(0));
        compare("reset passive line", wide_t'(o_cache_line_passive), wide_t'(0));
        $display("test 0 reset: %s", (err_count == errs_before) ? "ok" : "mismatch");

        for (int i = 0; i < n_cases; i++)
        begin
            run_case(i);
        end

        $display("%0d tests run, %0d errors", n_cases + 1, err_count);
        if (err_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/devil_cases.txt */
# cmd len line_seed pat_off pat_xor poison_seed arsnoop awsnoop araddr awaddr match
# pattern is len line words from pat_off, word 0 xored with pat_xor, past the end keeps counting
0 04 1a2b3c4d 03 00000000 5a5a0001 1 0 80001000 00000000 1
1 02 0badf00d 0a 00000000 77e10203 0 3 00000000 9000a040 1
0 10 31415926 00 00000000 00000000 b 0 0000ff80 00000000 1
1 01 27182818 0f 00000000 deadbeef 0 7 00000000 fffffffc 1
0 04 11223344 0e 00000000 00000000 1 0 80002000 00000000 0
1 03 55667788 05 00000040 12345678 0 2 00000000 40000000 0
5 02 99aabbcc 07 00000000 00000000 0 0 00000000 00000000 1
f 03 0ddba11f 00 80000000 00000000 0 0 00000000 00000000 0
0 08 c001d00d 08 00000000 00000000 d 0 00100040 00000000 1
1 10 600dcafe 01 00000000 a5a5a5a5 0 1 00000000 00200000 0
2 05 3c3c3c3c 0b 00000000 00000000 0 0 00000000 00000000 1
0 01 00000000 00 00000000 00000000 7 0 00000040 00000000 1

/* filelist.f */
logic/devil_pkg.sv
logic/devil_pattern_matcher.sv
logic/devil_controller_fsm.sv
logic/devil_controller.sv
testbench/devil_controller_assert.sv
testbench/tb_devil_controller.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the devil controller testbench with Verilator.
# Pass or fail is decided by the pass line in the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_devil_controller

verilator --binary --timing --assert -f filelist.f --top-module "$TOP" \
    --Mdir obj_dir -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL: pass line not found in $LOG"
    exit 1
fi
